/* design/cache_cfg_pkg.sv */
// cache geometry helper functions and the hit-stage state encoding
package cache_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // geometry helpers
  //////////////////////////////////////////////////////////////////////

  // sets = total bits / (line bits * ways)
  function automatic int no_of_sets(input int size, input int block_size, input int ways);
    return (size * 8) / (block_size * ways);
  endfunction

  // byte offset inside one line
  function automatic int no_of_block_offset_bits(input int block_size);
    return $clog2(block_size / 8);
  endfunction

  // set index width
  function automatic int no_of_index_bits(input int sets);
    return $clog2(sets);
  endfunction

  // whatever is left of the physical address
  function automatic int no_of_tag_bits(input int plen, input int idx_bits, input int offs_bits);
    return plen - idx_bits - offs_bits;
  endfunction

  // bus beats per line fill
  function automatic int no_of_beats(input int block_size, input int xlen);
    return block_size / xlen;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // hit-stage states
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    ARMED,
    INVALIDATE,
    NONCACHEABLE,
    FILL,
    RECOVER
  } cache_state_t;

endpackage

/* design/biu_pkg.sv */
// bus interface unit command encoding, data word type and bus constants
package biu_pkg;

  // width of one bus data beat
  localparam int BIU_DATA_W = 32;

  // bytes per beat, used for word alignment
  localparam int BIU_WORD_BYTES = BIU_DATA_W / 8;

  // one bus data word
  typedef logic [BIU_DATA_W-1:0] biu_word_t;

  // read-only command set
  // NOP when idle, READWORD is a single beat, READLINE is a full burst
  typedef enum logic [1:0] {
    BIUCMD_NOP      = 2'd0,
    BIUCMD_READWORD = 2'd1,
    BIUCMD_READLINE = 2'd2
  } biucmd_t;

endpackage

/* design/fill_if.sv */
// line-fill interface between hit FSM, beat counter and cache store
`timescale 1ns/1ps

interface fill_if #(
  parameter int XLEN       = 32,
  parameter int BLOCK_SIZE = 128,
  parameter int WAYS       = 2
);

  // fsm side of a fill
  logic                  fill_start;
  logic                  beat_ack;
  logic [XLEN-1:0]       beat_data;
  logic [WAYS-1:0]       fill_we;

  // counter side
  logic                  last_beat;
  logic [BLOCK_SIZE-1:0] fill_line;

  // store side, one-hot victim of the addressed set
  logic [WAYS-1:0]       fill_way;

  modport fsm (
    output fill_start, beat_ack, beat_data, fill_we,
    input  last_beat, fill_way
  );

  modport counter (
    input  fill_start, beat_ack, beat_data,
    output last_beat, fill_line
  );

  modport store (
    input  fill_we, fill_line,
    output fill_way
  );

endinterface

/* design/cache_hit_fsm.sv */
// hit-stage FSM: invalidate hold, miss and non-cacheable sequencing, stall and parcel outputs
`timescale 1ns/1ps

module cache_hit_fsm #(
  parameter int PLEN       = 32,
  parameter int BLOCK_SIZE = 128,
  parameter int WAYS       = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,

  // requester
  input  logic               req_i,
  input  logic [PLEN-1:0]    adr_i,
  input  logic               cacheable_i,
  input  logic               invalidate_i,

  // store lookup
  input  logic               hit_i,
  input  biu_pkg::biu_word_t hit_data_i,

  // bus response
  input  logic               biu_ack_i,
  input  logic               biu_err_i,
  input  biu_pkg::biu_word_t biu_q_i,

  fill_if.fsm                fill,

  output logic               invalidate_all_o,

  // bus request
  output logic               biu_req_o,
  output biu_pkg::biucmd_t   biu_cmd_o,
  output logic [PLEN-1:0]    biu_adr_o,

  // parcel back to requester
  output logic               stall_o,
  output biu_pkg::biu_word_t parcel_o,
  output logic               parcel_valid_o,
  output logic               parcel_error_o
);

  import cache_cfg_pkg::*;
  import biu_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // constants
  //////////////////////////////////////////////////////////////////////
  localparam int BLK_OFFS_BITS = no_of_block_offset_bits(BLOCK_SIZE);

  // masks for line base and word base
  localparam logic [PLEN-1:0] LINE_MASK = ~PLEN'((1 << BLK_OFFS_BITS) - 1);
  localparam logic [PLEN-1:0] WORD_MASK = ~PLEN'(BIU_WORD_BYTES - 1);

  cache_state_t state_q;
  cache_state_t state_d;

  logic inv_hold_q;
  logic inv_pend;
  logic go_word;
  logic go_fill;
  logic bus_err;

  // invalidate seen now or earlier, not yet serviced
  assign inv_pend = invalidate_i | inv_hold_q;

  // new bus transfers only start from ARMED, invalidate wins
  assign go_word = (state_q == ARMED) & ~inv_pend & req_i & ~cacheable_i;
  assign go_fill = (state_q == ARMED) & ~inv_pend & req_i & cacheable_i & ~hit_i;

  // error only counts while a transfer is outstanding
  assign bus_err = biu_err_i & ((state_q == FILL) | (state_q == NONCACHEABLE));

  // keep the pulse until ARMED takes it
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inv_hold_q <= 1'b0;
    else
      inv_hold_q <= inv_pend & (state_q != ARMED);
  end

  //////////////////////////////////////////////////////////////////////
  // state sequencing
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      ARMED:
      begin
        if (inv_pend)
          state_d = INVALIDATE;
        else if (go_word)
          state_d = NONCACHEABLE;
        else if (go_fill)
          state_d = FILL;
      end
      // valid bits drop at the edge leaving here
      INVALIDATE:   state_d = RECOVER;
      NONCACHEABLE:
      begin
        if (bus_err)
          state_d = RECOVER;
        else if (biu_ack_i)
          state_d = ARMED;
      end
      // last beat writes the line, an error drops it
      FILL:
      begin
        if (bus_err || fill.last_beat)
          state_d = RECOVER;
      end
      RECOVER:      state_d = ARMED;
      default:      state_d = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= ARMED;
    else
      state_q <= state_d;
  end

  //////////////////////////////////////////////////////////////////////
  // bus command
  //////////////////////////////////////////////////////////////////////

  // one-cycle request pulse on entry to FILL or NONCACHEABLE
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      biu_req_o <= 1'b0;
      biu_cmd_o <= BIUCMD_NOP;
    end
    else
    begin
      biu_req_o <= go_fill | go_word;
      if (go_fill)
        biu_cmd_o <= BIUCMD_READLINE;
      else if (go_word)
        biu_cmd_o <= BIUCMD_READWORD;
      else
        biu_cmd_o <= BIUCMD_NOP;
    end
  end

  // line base for a fill, word base for a single read
  always_ff @(posedge clk_i)
  begin
    if (go_fill)
      biu_adr_o <= adr_i & LINE_MASK;
    else if (go_word)
      biu_adr_o <= adr_i & WORD_MASK;
  end

  //////////////////////////////////////////////////////////////////////
  // fill control
  //////////////////////////////////////////////////////////////////////
  assign fill.fill_start = go_fill;
  assign fill.beat_ack   = (state_q == FILL) & biu_ack_i;
  assign fill.beat_data  = biu_q_i;

  // write the store's victim way with the completed line
  assign fill.fill_we = {WAYS{(state_q == FILL) & fill.last_beat & ~biu_err_i}} & fill.fill_way;

  assign invalidate_all_o = (state_q == INVALIDATE);

  //////////////////////////////////////////////////////////////////////
  // requester side
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    unique case (state_q)
      ARMED:        stall_o = inv_pend | (req_i & (~cacheable_i | ~hit_i));
      // released on the single ack or on error
      NONCACHEABLE: stall_o = ~(biu_ack_i | biu_err_i);
      // an error consumes the request, a good fill goes through RECOVER
      FILL:         stall_o = ~biu_err_i;
      default:      stall_o = 1'b1;
    endcase
  end

  // bus word only during a non-cacheable read
  assign parcel_o = (state_q == NONCACHEABLE) ? biu_q_i : hit_data_i;

  always_comb
  begin
    unique case (state_q)
      ARMED:        parcel_valid_o = req_i & cacheable_i & hit_i & ~inv_pend;
      NONCACHEABLE: parcel_valid_o = biu_ack_i & ~biu_err_i;
      default:      parcel_valid_o = 1'b0;
    endcase
  end

  assign parcel_error_o = bus_err;

endmodule

/* design/fill_beat_counter.sv */
// burst beat counter and line assembly for cache fills
`timescale 1ns/1ps

module fill_beat_counter #(
  parameter int XLEN       = 32,
  parameter int BLOCK_SIZE = 128
) (
  input logic     clk_i,
  input logic     rst_ni,
  fill_if.counter fill
);

  import cache_cfg_pkg::*;

  localparam int BEATS    = no_of_beats(BLOCK_SIZE, XLEN);
  localparam int CNT_BITS = (BEATS > 1) ? $clog2(BEATS) : 1;

  logic [CNT_BITS-1:0]   beat_cnt_q;
  logic [BLOCK_SIZE-1:0] line_q;
  logic [BLOCK_SIZE-1:0] line_d;

  // beat index, restarts with every fill
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      beat_cnt_q <= '0;
    else if (fill.fill_start)
      beat_cnt_q <= '0;
    else if (fill.beat_ack)
      beat_cnt_q <= beat_cnt_q + 1'b1;
  end

  // current beat merged in so the store sees a full line on the last ack
  always_comb
  begin
    line_d = line_q;
    if (fill.beat_ack)
      line_d[beat_cnt_q*XLEN +: XLEN] = fill.beat_data;
  end

  always_ff @(posedge clk_i)
  begin
    if (fill.beat_ack)
      line_q <= line_d;
  end

  assign fill.fill_line = line_d;

  // final beat of the burst
  assign fill.last_beat = fill.beat_ack & (beat_cnt_q == CNT_BITS'(BEATS - 1));

endmodule

/* design/cache_store.sv */
// tag, valid and line arrays with way compare, word select and per-set victim
`timescale 1ns/1ps

module cache_store #(
  parameter int XLEN       = 32,
  parameter int PLEN       = 32,
  parameter int SIZE       = 256,
  parameter int BLOCK_SIZE = 128,
  parameter int WAYS       = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic [PLEN-1:0]    adr_i,
  input  logic               invalidate_all_i,

  fill_if.store              fill,

  output logic               hit_o,
  output biu_pkg::biu_word_t hit_data_o
);

  import cache_cfg_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////////////////
  localparam int SETS          = no_of_sets(SIZE, BLOCK_SIZE, WAYS);
  localparam int BLK_OFFS_BITS = no_of_block_offset_bits(BLOCK_SIZE);
  localparam int IDX_BITS      = no_of_index_bits(SETS);
  localparam int TAG_BITS      = no_of_tag_bits(PLEN, IDX_BITS, BLK_OFFS_BITS);
  localparam int WORD_LSB      = $clog2(XLEN / 8);
  localparam int WORD_BITS     = (BLK_OFFS_BITS > WORD_LSB) ? BLK_OFFS_BITS - WORD_LSB : 1;
  localparam int VICT_BITS     = (WAYS > 1) ? $clog2(WAYS) : 1;

  // arrays
  logic [TAG_BITS-1:0]   tag_q  [WAYS][SETS];
  logic [BLOCK_SIZE-1:0] data_q [WAYS][SETS];
  logic [WAYS-1:0][SETS-1:0]      valid_q;
  logic [SETS-1:0][VICT_BITS-1:0] victim_q;

  // address split
  logic [IDX_BITS-1:0]  idx;
  logic [TAG_BITS-1:0]  adr_tag;
  logic [WORD_BITS-1:0] word_sel;

  logic [WAYS-1:0]       hit_way;
  logic [BLOCK_SIZE-1:0] hit_line;

  assign idx      = adr_i[BLK_OFFS_BITS +: IDX_BITS];
  assign adr_tag  = adr_i[PLEN-1 -: TAG_BITS];
  assign word_sel = WORD_BITS'(adr_i[BLK_OFFS_BITS-1:0] >> WORD_LSB);

  //////////////////////////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////////////////////////

  // tag compare in every way
  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
      hit_way[w] = valid_q[w][idx] & (tag_q[w][idx] == adr_tag);
  end

  // at most one way hits
  always_comb
  begin
    hit_line = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (hit_way[w])
        hit_line = data_q[w][idx];
    end
  end

  assign hit_o      = |hit_way;
  assign hit_data_o = hit_line[word_sel*XLEN +: XLEN];

  // victim of the addressed set, one-hot
  assign fill.fill_way = WAYS'(1) << victim_q[idx];

  //////////////////////////////////////////////////////////////////////
  // fill write
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    for (int w = 0; w < WAYS; w++)
    begin
      if (fill.fill_we[w])
      begin
        tag_q[w][idx]  <= adr_tag;
        data_q[w][idx] <= fill.fill_line;
      end
    end
  end

  // valid bits and victim pointers
  // the victim moves on after each fill, back to way 0 on invalidate
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q  <= '0;
      victim_q <= '0;
    end
    else if (invalidate_all_i)
    begin
      valid_q  <= '0;
      victim_q <= '0;
    end
    else if (|fill.fill_we)
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        if (fill.fill_we[w])
          valid_q[w][idx] <= 1'b1;
      end
      if (victim_q[idx] == VICT_BITS'(WAYS - 1))
        victim_q[idx] <= '0;
      else
        victim_q[idx] <= victim_q[idx] + 1'b1;
    end
  end

endmodule

/* design/icache_top.sv */
// read-only cache top level: hit FSM, fill beat counter and store
`timescale 1ns/1ps

module icache_top #(
  parameter int XLEN       = 32,
  parameter int PLEN       = 32,
  parameter int SIZE       = 256,
  parameter int BLOCK_SIZE = 128,
  parameter int WAYS       = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,

  // requester
  input  logic               req_i,
  input  logic [PLEN-1:0]    adr_i,
  input  logic               cacheable_i,
  input  logic               invalidate_i,
  output logic               stall_o,
  output biu_pkg::biu_word_t parcel_o,
  output logic               parcel_valid_o,
  output logic               parcel_error_o,

  // bus interface unit
  output logic               biu_req_o,
  output biu_pkg::biucmd_t   biu_cmd_o,
  output logic [PLEN-1:0]    biu_adr_o,
  input  logic               biu_ack_i,
  input  biu_pkg::biu_word_t biu_q_i,
  input  logic               biu_err_i
);

  // lookup result and invalidate strobe
  logic               hit;
  biu_pkg::biu_word_t hit_data;
  logic               invalidate_all;

  // line fill path
  fill_if #(
    .XLEN       (XLEN),
    .BLOCK_SIZE (BLOCK_SIZE),
    .WAYS       (WAYS)
  ) u_fill ();

  cache_hit_fsm #(
    .PLEN       (PLEN),
    .BLOCK_SIZE (BLOCK_SIZE),
    .WAYS       (WAYS)
  ) u_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .adr_i            (adr_i),
    .cacheable_i      (cacheable_i),
    .invalidate_i     (invalidate_i),
    .hit_i            (hit),
    .hit_data_i       (hit_data),
    .biu_ack_i        (biu_ack_i),
    .biu_err_i        (biu_err_i),
    .biu_q_i          (biu_q_i),
    .fill             (u_fill.fsm),
    .invalidate_all_o (invalidate_all),
    .biu_req_o        (biu_req_o),
    .biu_cmd_o        (biu_cmd_o),
    .biu_adr_o        (biu_adr_o),
    .stall_o          (stall_o),
    .parcel_o         (parcel_o),
    .parcel_valid_o   (parcel_valid_o),
    .parcel_error_o   (parcel_error_o)
  );

  fill_beat_counter #(
    .XLEN       (XLEN),
    .BLOCK_SIZE (BLOCK_SIZE)
  ) u_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .fill   (u_fill.counter)
  );

  // request address goes straight to the arrays
  cache_store #(
    .XLEN       (XLEN),
    .PLEN       (PLEN),
    .SIZE       (SIZE),
    .BLOCK_SIZE (BLOCK_SIZE),
    .WAYS       (WAYS)
  ) u_store (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .adr_i            (adr_i),
    .invalidate_all_i (invalidate_all),
    .fill             (u_fill.store),
    .hit_o            (hit),
    .hit_data_o       (hit_data)
  );

endmodule

/* bench/icache_sva.sv */
// concurrent checks on the hit FSM: request pulse, bus wait, fill write and recover length
`timescale 1ns/1ps

module icache_sva #(
  parameter int WAYS = 2
) (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        biu_req_i,
  input cache_cfg_pkg::cache_state_t state_i,
  input logic [WAYS-1:0]             fill_we_i,
  input logic                        last_beat_i,
  input logic                        hit_i
);

  import cache_cfg_pkg::*;

  // count of failed assertions
  int fail_count = 0;

  // request strobe is a single cycle
  a_req_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_req_i |=> !biu_req_i)
    else
    begin
      fail_count++;
      $error("biu_req_o stayed high for more than one cycle");
    end

  // no second request while a transfer is outstanding
  a_req_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((state_i == FILL || state_i == NONCACHEABLE) && state_i == $past(state_i)) |-> !biu_req_i)
    else
    begin
      fail_count++;
      $error("new bus request while a transfer was still waiting");
    end

  // final beat writes exactly one victim way, nothing else writes
  a_fill_we: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((|fill_we_i) || last_beat_i) |-> (last_beat_i && $onehot(fill_we_i)))
    else
    begin
      fail_count++;
      $error("fill write not on the last beat or not to a single way");
    end

  // one RECOVER cycle after a fill, then the held request hits
  a_recover: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|fill_we_i) |=> (state_i == RECOVER) ##1 (state_i == ARMED && hit_i))
    else
    begin
      fail_count++;
      $error("filled line did not hit after a single RECOVER cycle");
    end

endmodule

bind cache_hit_fsm icache_sva #(.WAYS(WAYS)) u_sva (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .biu_req_i   (biu_req_o),
  .state_i     (state_q),
  .fill_we_i   (fill.fill_we),
  .last_beat_i (fill.last_beat),
  .hit_i       (hit_i)
);

/* bench/icache_tb.sv */
// icache testbench: clock, reset, xorshift stimulus, bus memory model, reference model, checks
`timescale 1ns/1ps

module icache_tb;

  import biu_pkg::*;

  localparam int XLEN       = 32;
  localparam int PLEN       = 32;
  localparam int SIZE       = 256;
  localparam int BLOCK_SIZE = 128;
  localparam int WAYS       = 2;

  // geometry as the reference model sees it
  localparam int LINE_BYTES = BLOCK_SIZE / 8;
  localparam int BEATS      = BLOCK_SIZE / XLEN;
  localparam int SETS       = SIZE / (LINE_BYTES * WAYS);

  localparam int DIRECTED_REQ = 25;
  localparam int RANDOM_REQ   = 300;
  localparam int TIMEOUT_CYC  = 400 * (DIRECTED_REQ + RANDOM_REQ);

  localparam logic [31:0] SEED    = 32'h3e84_2834;
  localparam logic [31:0] MEM_KEY = 32'h5a5a_0000;

  logic            clk_i;
  logic            rst_ni;
  logic            req_i;
  logic [PLEN-1:0] adr_i;
  logic            cacheable_i;
  logic            invalidate_i;
  logic            stall_o;
  biu_word_t       parcel_o;
  logic            parcel_valid_o;
  logic            parcel_error_o;
  logic            biu_req_o;
  biucmd_t         biu_cmd_o;
  logic [PLEN-1:0] biu_adr_o;
  logic            biu_ack_i;
  biu_word_t       biu_q_i;
  logic            biu_err_i;

  logic [31:0] rnd_state;
  string       test_name;
  int          err_count;
  int          check_count;
  int          cycle_count;
  // 0 no bus errors, 1 random errors, 2 every transfer fails
  int          err_mode;

  // last transfer seen by the memory model
  int          xfer_count;
  biucmd_t     xfer_cmd;
  logic [31:0] xfer_adr;
  logic        xfer_err;

  // reference copy of sets, line numbers and victims
  logic        m_valid  [WAYS][SETS];
  logic [31:0] m_line   [WAYS][SETS];
  int          m_victim [SETS];

  icache_top #(
    .XLEN       (XLEN),
    .PLEN       (PLEN),
    .SIZE       (SIZE),
    .BLOCK_SIZE (BLOCK_SIZE),
    .WAYS       (WAYS)
  ) u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .adr_i          (adr_i),
    .cacheable_i    (cacheable_i),
    .invalidate_i   (invalidate_i),
    .stall_o        (stall_o),
    .parcel_o       (parcel_o),
    .parcel_valid_o (parcel_valid_o),
    .parcel_error_o (parcel_error_o),
    .biu_req_o      (biu_req_o),
    .biu_cmd_o      (biu_cmd_o),
    .biu_adr_o      (biu_adr_o),
    .biu_ack_i      (biu_ack_i),
    .biu_q_i        (biu_q_i),
    .biu_err_i      (biu_err_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rnd_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rnd_state = x;
    return x;
  endfunction

  function automatic int set_index(input logic [31:0] adr);
    return int'((adr / LINE_BYTES) % SETS);
  endfunction

  function automatic logic predict_hit(input logic [31:0] adr);
    int   s;
    logic h;
    s = set_index(adr);
    h = 1'b0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (m_valid[w][s] && m_line[w][s] == adr / LINE_BYTES)
        h = 1'b1;
    end
    return h;
  endfunction

  // victim way takes the line, pointer moves on
  function automatic void allocate_line(input logic [31:0] adr);
    int s;
    int w;
    s = set_index(adr);
    w = m_victim[s];
    m_valid[w][s] = 1'b1;
    m_line[w][s]  = adr / LINE_BYTES;
    m_victim[s]   = (w + 1) % WAYS;
  endfunction

  function automatic void clear_lines();
    for (int s = 0; s < SETS; s++)
    begin
      m_victim[s] = 0;
      for (int w = 0; w < WAYS; w++)
        m_valid[w][s] = 1'b0;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_word(input string what, input biu_word_t exp, input biu_word_t act);
    check_count++;
    if (exp !== act)
    begin
      err_count++;
      $display("MISMATCH %s %s expected %08h actual %08h", test_name, what, exp, act);
    end
  endtask

  task automatic check_cmd(input string what, input biucmd_t exp, input biucmd_t act);
    check_count++;
    if (exp !== act)
    begin
      err_count++;
      $display("MISMATCH %s %s expected %s actual %s", test_name, what, exp.name(), act.name());
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    check_count++;
    if (exp !== act)
    begin
      err_count++;
      $display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus memory model
  //////////////////////////////////////////////////////////////////////
  initial
  begin : bus_model
    int          beats;
    int          err_beat;
    int          waits [BEATS];
    logic        do_err;
    logic [31:0] r;
    logic [31:0] base;
    biu_ack_i = 1'b0;
    biu_err_i = 1'b0;
    biu_q_i   = '0;
    forever
    begin
      @(negedge clk_i);
      if (rst_ni && biu_req_o)
      begin
        xfer_count++;
        xfer_cmd = biu_cmd_o;
        xfer_adr = biu_adr_o;
        base     = biu_adr_o;
        beats    = (biu_cmd_o == BIUCMD_READLINE) ? BEATS : 1;
        // error and wait cycles fixed once per transfer
        r        = next_rand();
        do_err   = (err_mode == 2) || (err_mode == 1 && r[4:0] == 5'd0);
        err_beat = int'(r[31:16] % 16'(beats));
        xfer_err = do_err;
        for (int b = 0; b < beats; b++)
          waits[b] = int'(next_rand() % 32'd4);
        for (int b = 0; b < beats; b++)
        begin
          repeat (waits[b])
          begin
            @(posedge clk_i);
            #2;
            biu_ack_i = 1'b0;
          end
          @(posedge clk_i);
          #2;
          // error replaces the ack and ends the burst
          if (do_err && b == err_beat)
          begin
            biu_ack_i = 1'b0;
            biu_err_i = 1'b1;
            break;
          end
          biu_ack_i = 1'b1;
          biu_q_i   = (base + 32'(4 * b)) ^ MEM_KEY;
        end
        @(posedge clk_i);
        #2;
        biu_ack_i = 1'b0;
        biu_err_i = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // requester
  //////////////////////////////////////////////////////////////////////
  task automatic run_request(input logic [31:0] adr, input logic cach, input logic inv);
    logic        exp_hit;
    logic        exp_bus;
    logic        got_err;
    biucmd_t     exp_cmd;
    logic [31:0] exp_adr;
    int          start_count;
    // invalidate is serviced ahead of the request
    if (inv)
      clear_lines();
    exp_hit     = cach && predict_hit(adr);
    exp_bus     = !exp_hit;
    exp_cmd     = cach ? BIUCMD_READLINE : BIUCMD_READWORD;
    exp_adr     = cach ? (adr & ~32'(LINE_BYTES - 1)) : (adr & ~32'h3);
    start_count = xfer_count;
    got_err     = 1'b0;
    @(posedge clk_i);
    #2;
    req_i        = 1'b1;
    adr_i        = adr;
    cacheable_i  = cach;
    invalidate_i = inv;
    // held steady until stall drops
    @(negedge clk_i);
    while (stall_o)
    begin
      @(posedge clk_i);
      #2;
      invalidate_i = 1'b0;
      @(negedge clk_i);
    end
    check_bit("bus request", exp_bus, xfer_count != start_count);
    if (exp_bus && xfer_count != start_count)
    begin
      check_cmd("bus command", exp_cmd, xfer_cmd);
      check_word("bus address", exp_adr, xfer_adr);
      got_err = xfer_err;
    end
    check_bit("parcel valid", !got_err, parcel_valid_o);
    check_bit("parcel error", got_err, parcel_error_o);
    if (!got_err)
      check_word("parcel", (adr & ~32'h3) ^ MEM_KEY, parcel_o);
    if (cach && !exp_hit && !got_err)
      allocate_line(adr);
  endtask

  // one-cycle invalidate with no request
  task automatic pulse_invalidate();
    clear_lines();
    @(posedge clk_i);
    #2;
    req_i        = 1'b0;
    invalidate_i = 1'b1;
    @(posedge clk_i);
    #2;
    invalidate_i = 1'b0;
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    #2;
    req_i        = 1'b0;
    invalidate_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial
  begin : main
    logic [31:0] r;
    logic [31:0] adr;
    int          sva_fails;
    rst_ni       = 1'b0;
    req_i        = 1'b0;
    adr_i        = '0;
    cacheable_i  = 1'b0;
    invalidate_i = 1'b0;
    rnd_state    = SEED;
    err_count    = 0;
    check_count  = 0;
    err_mode     = 0;
    xfer_count   = 0;
    test_name    = "reset";
    clear_lines();
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("idle stall", 1'b0, stall_o);
    check_bit("idle bus request", 1'b0, biu_req_o);
    check_bit("idle parcel valid", 1'b0, parcel_valid_o);
    check_bit("idle parcel error", 1'b0, parcel_error_o);

    test_name = "miss_then_hit";
    run_request(32'h0000_0100, 1'b1, 1'b0);
    run_request(32'h0000_0104, 1'b1, 1'b0);
    run_request(32'h0000_010c, 1'b1, 1'b0);
    run_request(32'h0000_0100, 1'b1, 1'b0);

    // three lines fighting over set 0
    test_name = "conflict_victim";
    run_request(32'h0000_0180, 1'b1, 1'b0);
    run_request(32'h0000_0100, 1'b1, 1'b0);
    run_request(32'h0000_0180, 1'b1, 1'b0);
    run_request(32'h0000_0200, 1'b1, 1'b0);
    run_request(32'h0000_0184, 1'b1, 1'b0);
    run_request(32'h0000_0100, 1'b1, 1'b0);
    run_request(32'h0000_0208, 1'b1, 1'b0);
    run_request(32'h0000_0180, 1'b1, 1'b0);

    test_name = "noncacheable";
    run_request(32'h0000_0300, 1'b0, 1'b0);
    run_request(32'h0000_0304, 1'b0, 1'b0);
    run_request(32'h0000_0300, 1'b1, 1'b0);
    run_request(32'h0000_0300, 1'b0, 1'b0);

    test_name = "invalidate";
    run_request(32'h0000_0300, 1'b1, 1'b0);
    run_request(32'h0000_0300, 1'b1, 1'b1);
    run_request(32'h0000_0300, 1'b1, 1'b0);
    pulse_invalidate();
    run_request(32'h0000_0300, 1'b1, 1'b0);

    test_name = "bus_error";
    err_mode  = 2;
    run_request(32'h0000_0440, 1'b1, 1'b0);
    err_mode  = 0;
    run_request(32'h0000_0440, 1'b1, 1'b0);
    run_request(32'h0000_0448, 1'b1, 1'b0);
    err_mode  = 2;
    run_request(32'h0000_0500, 1'b0, 1'b0);
    err_mode  = 0;
    run_request(32'h0000_0500, 1'b0, 1'b0);

    // 16 lines on four sets, word, flag and invalidates from the same draw
    test_name = "random_mix";
    err_mode  = 1;
    for (int i = 0; i < RANDOM_REQ; i++)
    begin
      r   = next_rand();
      adr = 32'h0000_4000 + 32'(r[3:0]) * 32'h20 + 32'(r[5:4]) * 32'h4;
      if (r[15:12] == 4'd0)
        pulse_invalidate();
      else if (r[11:9] == 3'd0)
        idle_cycle();
      run_request(adr, r[8:7] != 2'b00, r[20:16] == 5'd0);
    end

    err_mode = 0;
    idle_cycle();
    repeat (4) @(posedge clk_i);
    sva_fails = u_dut.u_fsm.u_sva.fail_count;
    $display("checks: %0d  errors: %0d  assertion failures: %0d",
             check_count, err_count, sva_fails);
    if (err_count == 0 && sva_fails == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // run limit scales with the request count
  initial
  begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYC)
    begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("TIMEOUT: no verdict after %0d clock cycles, checks: %0d  errors: %0d",
             TIMEOUT_CYC, check_count, err_count);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* icache.f */
design/cache_cfg_pkg.sv
design/biu_pkg.sv
design/fill_if.sv
design/cache_hit_fsm.sv
design/fill_beat_counter.sv
design/cache_store.sv
design/icache_top.sv
bench/icache_sva.sv
bench/icache_tb.sv

/* run_icache.sh */
#!/bin/sh
# build the icache testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

log=icache_sim.log

verilator --binary --timing --assert --top-module icache_tb -f icache.f -o icache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/icache_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q -F '*** FAILED ***' "$log"; then
  echo "testbench reported a failure"
  exit 1
fi
exit 0
